//--- sources.f
roce_proto_pkg.sv
roce_cfg_pkg.sv
payload_stream_if.sv
packet_desc_if.sv
tx_segmenter.sv
header_builder.sv
payload_skid_buffer.sv
roce_tx_top.sv
tb_roce_tx.sv

//--- tb_roce_tx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_roce_tx;

    localparam int data_width = 64;
    localparam int num_transfers = 16;
    localparam int wait_limit = 1000;
    localparam logic [31:0] seed = 32'h4ace75ee;

    logic                    clk;
    logic                    rst;
    logic                    s_dma_meta_valid;
    logic                    s_dma_meta_ready;
    logic [31:0]             s_dma_length;
    logic [23:0]             s_rem_qpn;
    logic [23:0]             s_loc_qpn;
    logic [23:0]             s_rem_psn;
    logic [31:0]             s_r_key;
    logic [63:0]             s_rem_addr;
    logic                    s_is_immediate;
    logic [31:0]             s_immediate_data;
    logic                    s_transfer_type;
    logic [data_width-1:0]   s_axis_tdata;
    logic [data_width/8-1:0] s_axis_tkeep;
    logic                    s_axis_tvalid;
    logic                    s_axis_tready;
    logic                    m_roce_bth_valid;
    logic                    m_roce_bth_ready;
    logic [7:0]              m_roce_bth_op_code;
    logic [23:0]             m_roce_bth_psn;
    logic [23:0]             m_roce_bth_dest_qp;
    logic [23:0]             m_roce_bth_src_qp;
    logic                    m_roce_reth_valid;
    logic                    m_roce_reth_ready;
    logic [63:0]             m_roce_reth_v_addr;
    logic [31:0]             m_roce_reth_r_key;
    logic [31:0]             m_roce_reth_length;
    logic                    m_roce_immdh_valid;
    logic                    m_roce_immdh_ready;
    logic [31:0]             m_roce_immdh_data;
    logic [15:0]             m_udp_length;
    logic [data_width-1:0]   m_roce_payload_axis_tdata;
    logic [data_width/8-1:0] m_roce_payload_axis_tkeep;
    logic                    m_roce_payload_axis_tvalid;
    logic                    m_roce_payload_axis_tready;
    logic                    m_roce_payload_axis_tlast;
    logic [2:0]              pmtu;

    logic [31:0] stim_rng;
    logic [31:0] ready_rng;

    // expected outputs in arrival order
    logic [95:0]  exp_bth[$];
    logic [127:0] exp_reth[$];
    logic [31:0]  exp_immdh[$];
    logic [64:0]  exp_beat[$];
    // per packet, RETH valid and IMMDH valid
    logic [1:0]   exp_hdr_set[$];

    logic [95:0]  bth_word;
    logic [127:0] reth_word;
    logic [64:0]  beat_word;
    logic         bth_was_valid;

    roce_tx_top #(.data_width(data_width)) dut (
        .clk(clk), .rst(rst),
        .s_dma_meta_valid(s_dma_meta_valid), .s_dma_meta_ready(s_dma_meta_ready),
        .s_dma_length(s_dma_length), .s_rem_qpn(s_rem_qpn), .s_loc_qpn(s_loc_qpn),
        .s_rem_psn(s_rem_psn), .s_r_key(s_r_key), .s_rem_addr(s_rem_addr),
        .s_is_immediate(s_is_immediate), .s_immediate_data(s_immediate_data),
        .s_transfer_type(s_transfer_type),
        .s_axis_tdata(s_axis_tdata), .s_axis_tkeep(s_axis_tkeep),
        .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
        .m_roce_bth_valid(m_roce_bth_valid), .m_roce_bth_ready(m_roce_bth_ready),
        .m_roce_bth_op_code(m_roce_bth_op_code), .m_roce_bth_psn(m_roce_bth_psn),
        .m_roce_bth_dest_qp(m_roce_bth_dest_qp), .m_roce_bth_src_qp(m_roce_bth_src_qp),
        .m_roce_reth_valid(m_roce_reth_valid), .m_roce_reth_ready(m_roce_reth_ready),
        .m_roce_reth_v_addr(m_roce_reth_v_addr), .m_roce_reth_r_key(m_roce_reth_r_key),
        .m_roce_reth_length(m_roce_reth_length),
        .m_roce_immdh_valid(m_roce_immdh_valid), .m_roce_immdh_ready(m_roce_immdh_ready),
        .m_roce_immdh_data(m_roce_immdh_data), .m_udp_length(m_udp_length),
        .m_roce_payload_axis_tdata(m_roce_payload_axis_tdata),
        .m_roce_payload_axis_tkeep(m_roce_payload_axis_tkeep),
        .m_roce_payload_axis_tvalid(m_roce_payload_axis_tvalid),
        .m_roce_payload_axis_tready(m_roce_payload_axis_tready),
        .m_roce_payload_axis_tlast(m_roce_payload_axis_tlast),
        .pmtu(pmtu)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s is %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    task automatic wait_for_meta_ready(input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!s_dma_meta_ready && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!s_dma_meta_ready) begin
            abort_run(what);
        end
    endtask

    task automatic wait_for_input_ready(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!s_axis_tready && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!s_axis_tready) begin
            abort_run("timeout waiting for s_axis_tready on a payload beat");
        end
    endtask

    // builds the expected packets of one transfer, then drives it
    task automatic run_transfer();
        int          beats;
        int          len;
        int          pmtu_b;
        int          npkt;
        int          plen;
        logic        first;
        logic        last;
        logic [7:0]  op;
        logic [15:0] udp;
        logic [23:0] psn;
        logic [63:0] data;
        logic [63:0] beat_q[$];

        @(posedge clk);
        #1;
        stim_rng = lcg_step(stim_rng);
        beats = 1 + stim_rng[31:16] % 150;
        stim_rng = lcg_step(stim_rng);
        s_transfer_type = stim_rng[31];
        s_is_immediate  = stim_rng[30];
        pmtu            = {2'b00, stim_rng[29]};
        s_rem_psn       = 24'hfffffc + {22'd0, stim_rng[25:24]};
        stim_rng = lcg_step(stim_rng);
        s_rem_qpn = stim_rng[31:8];
        stim_rng = lcg_step(stim_rng);
        s_loc_qpn = stim_rng[31:8];
        stim_rng = lcg_step(stim_rng);
        s_r_key = stim_rng;
        stim_rng = lcg_step(stim_rng);
        s_immediate_data = stim_rng;
        stim_rng = lcg_step(stim_rng);
        s_rem_addr[63:32] = stim_rng;
        stim_rng = lcg_step(stim_rng);
        s_rem_addr[31:0] = stim_rng;
        len = beats * 8;
        s_dma_length = len;

        pmtu_b = 256 << pmtu;
        npkt = (len + pmtu_b - 1) / pmtu_b;
        psn = s_rem_psn;
        for (int i = 0; i < npkt; i++) begin
            first = (i == 0);
            last  = (i == npkt - 1);
            plen  = last ? len - i * pmtu_b : pmtu_b;
            if (first && last) op = 8'd4;
            else if (first) op = 8'd0;
            else if (last) op = 8'd2;
            else op = 8'd1;
            if (last && s_is_immediate) op = op + 8'd1;
            if (s_transfer_type) op = op + 8'd6;
            // payload, BTH and UDP header, plus optional RETH and IMMDH
            udp = plen + 12 + 8;
            if (s_transfer_type && first) udp = udp + 16'd16;
            if (s_is_immediate && last) udp = udp + 16'd4;
            exp_bth.push_back({op, psn, s_rem_qpn, s_loc_qpn, udp});
            exp_hdr_set.push_back({s_transfer_type && first, s_is_immediate && last});
            if (s_transfer_type && first) begin
                exp_reth.push_back({s_rem_addr, s_r_key, s_dma_length});
            end
            if (s_is_immediate && last) begin
                exp_immdh.push_back(s_immediate_data);
            end
            psn = psn + 24'd1;
        end

        for (int b = 0; b < beats; b++) begin
            stim_rng = lcg_step(stim_rng);
            data[63:32] = stim_rng;
            stim_rng = lcg_step(stim_rng);
            data[31:0] = stim_rng;
            last = ((b + 1) * 8 % pmtu_b == 0) || (b == beats - 1);
            exp_beat.push_back({last, data});
            beat_q.push_back(data);
        end

        @(posedge clk);
        #1;
        s_dma_meta_valid = 1'b1;
        wait_for_meta_ready(wait_limit, "timeout waiting for the descriptor to be accepted");
        @(posedge clk);
        #1;
        s_dma_meta_valid = 1'b0;

        for (int b = 0; b < beats; b++) begin
            stim_rng = lcg_step(stim_rng);
            if (stim_rng[31:29] == 3'd0) begin
                s_axis_tvalid = 1'b0;
                @(posedge clk);
                #1;
            end
            s_axis_tvalid = 1'b1;
            s_axis_tdata  = beat_q[b];
            s_axis_tkeep  = '1;
            wait_for_input_ready(wait_limit);
            @(posedge clk);
            #1;
        end
        s_axis_tvalid = 1'b0;
    endtask

    // random stalls on every output ready
    initial begin
        m_roce_bth_ready = 1'b0;
        m_roce_reth_ready = 1'b0;
        m_roce_immdh_ready = 1'b0;
        m_roce_payload_axis_tready = 1'b0;
        ready_rng = lcg_step(seed ^ 32'h0000ffff);
        forever begin
            @(posedge clk);
            #1;
            ready_rng = lcg_step(ready_rng);
            m_roce_bth_ready = ready_rng[31] | ready_rng[30];
            m_roce_reth_ready = ready_rng[29] | ready_rng[28];
            m_roce_immdh_ready = ready_rng[27] | ready_rng[26];
            m_roce_payload_axis_tready = ready_rng[25] | ready_rng[24];
        end
    end

    // a new header set raises RETH and IMMDH together with BTH, only where needed
    always @(negedge clk) begin
        if (!rst && m_roce_bth_valid && !bth_was_valid) begin
            if (exp_hdr_set.size() == 0) begin
                abort_run("a header set came out with no packet left to send");
            end else begin
                check_value({m_roce_reth_valid, m_roce_immdh_valid}, exp_hdr_set.pop_front(),
                            "reth and immdh valid with a new bth");
            end
        end
        bth_was_valid = !rst && m_roce_bth_valid;
    end

    always @(negedge clk) begin
        if (!rst && m_roce_bth_valid && m_roce_bth_ready) begin
            if (exp_bth.size() == 0) begin
                abort_run("a BTH came out with no packet left to send");
            end else begin
                bth_word = exp_bth.pop_front();
                check_value(m_roce_bth_op_code, bth_word[95:88], "bth opcode");
                check_value(m_roce_bth_psn, bth_word[87:64], "bth psn");
                check_value(m_roce_bth_dest_qp, bth_word[63:40], "bth dest qp");
                check_value(m_roce_bth_src_qp, bth_word[39:16], "bth src qp");
                check_value(m_udp_length, bth_word[15:0], "udp length");
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && m_roce_reth_valid && m_roce_reth_ready) begin
            if (exp_reth.size() == 0) begin
                abort_run("a RETH came out where none was expected");
            end else begin
                reth_word = exp_reth.pop_front();
                check_value(m_roce_reth_v_addr, reth_word[127:64], "reth address");
                check_value(m_roce_reth_r_key, reth_word[63:32], "reth r_key");
                check_value(m_roce_reth_length, reth_word[31:0], "reth length");
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && m_roce_immdh_valid && m_roce_immdh_ready) begin
            if (exp_immdh.size() == 0) begin
                abort_run("an IMMDH came out where none was expected");
            end else begin
                check_value(m_roce_immdh_data, exp_immdh.pop_front(), "immediate data");
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && m_roce_payload_axis_tvalid && m_roce_payload_axis_tready) begin
            if (exp_beat.size() == 0) begin
                abort_run("a payload beat came out that was never sent");
            end else begin
                beat_word = exp_beat.pop_front();
                check_value(m_roce_payload_axis_tdata, beat_word[63:0], "payload data");
                check_value(m_roce_payload_axis_tlast, beat_word[64], "payload tlast");
                check_value(m_roce_payload_axis_tkeep, 8'hff, "payload tkeep");
            end
        end
    end

    initial begin
        int n;
        rst = 1'b1;
        bth_was_valid = 1'b0;
        s_dma_meta_valid = 1'b0;
        s_dma_length = '0;
        s_rem_qpn = '0;
        s_loc_qpn = '0;
        s_rem_psn = '0;
        s_r_key = '0;
        s_rem_addr = '0;
        s_is_immediate = 1'b0;
        s_immediate_data = '0;
        s_transfer_type = 1'b0;
        s_axis_tdata = '0;
        s_axis_tkeep = '0;
        s_axis_tvalid = 1'b0;
        pmtu = '0;
        stim_rng = seed;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value({m_roce_bth_valid, m_roce_reth_valid, m_roce_immdh_valid,
                     m_roce_payload_axis_tvalid, s_dma_meta_ready, s_axis_tready},
                    '0, "valids and readies just after reset");
        wait_for_meta_ready(1, "s_dma_meta_ready did not rise after reset");

        for (int t = 0; t < num_transfers; t++) begin
            run_transfer();
        end

        // let the last headers and beats drain
        n = 0;
        while ((exp_bth.size() + exp_reth.size() + exp_immdh.size() + exp_beat.size()) != 0
               && n < 4 * wait_limit) begin
            @(negedge clk);
            n++;
        end
        if ((exp_bth.size() + exp_reth.size() + exp_immdh.size() + exp_beat.size()) != 0) begin
            abort_run("timeout: headers or payload beats never came out");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- roce_tx_top.sv
`timescale 1ns/100ps
`default_nettype none

module roce_tx_top
    import roce_cfg_pkg::*;
#(
    parameter int data_width = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s_dma_meta_valid,
    output logic                    s_dma_meta_ready,
    input  dma_len_t                s_dma_length,
    input  qpn_t                    s_rem_qpn,
    input  qpn_t                    s_loc_qpn,
    input  psn_t                    s_rem_psn,
    input  logic [31:0]             s_r_key,
    input  logic [63:0]             s_rem_addr,
    input  logic                    s_is_immediate,
    input  logic [31:0]             s_immediate_data,
    input  logic                    s_transfer_type,
    input  logic [data_width-1:0]   s_axis_tdata,
    input  logic [data_width/8-1:0] s_axis_tkeep,
    input  logic                    s_axis_tvalid,
    output logic                    s_axis_tready,
    output logic                    m_roce_bth_valid,
    input  logic                    m_roce_bth_ready,
    output logic [7:0]              m_roce_bth_op_code,
    output psn_t                    m_roce_bth_psn,
    output qpn_t                    m_roce_bth_dest_qp,
    output qpn_t                    m_roce_bth_src_qp,
    output logic                    m_roce_reth_valid,
    input  logic                    m_roce_reth_ready,
    output logic [63:0]             m_roce_reth_v_addr,
    output logic [31:0]             m_roce_reth_r_key,
    output dma_len_t                m_roce_reth_length,
    output logic                    m_roce_immdh_valid,
    input  logic                    m_roce_immdh_ready,
    output logic [31:0]             m_roce_immdh_data,
    output logic [15:0]             m_udp_length,
    output logic [data_width-1:0]   m_roce_payload_axis_tdata,
    output logic [data_width/8-1:0] m_roce_payload_axis_tkeep,
    output logic                    m_roce_payload_axis_tvalid,
    input  logic                    m_roce_payload_axis_tready,
    output logic                    m_roce_payload_axis_tlast,
    input  pmtu_code_t              pmtu
);

    payload_stream_if #(.data_width(data_width)) pay_if ();
    packet_desc_if desc_if ();

    tx_segmenter #(.data_width(data_width)) u_segmenter (
        .clk(clk), .rst(rst), .pmtu(pmtu),
        .meta_valid(s_dma_meta_valid), .meta_ready(s_dma_meta_ready),
        .dma_length(s_dma_length), .rem_qpn(s_rem_qpn), .loc_qpn(s_loc_qpn),
        .rem_psn(s_rem_psn), .r_key(s_r_key), .imm_data(s_immediate_data),
        .rem_addr(s_rem_addr), .is_imm(s_is_immediate), .is_write(s_transfer_type),
        .in_tdata(s_axis_tdata), .in_tkeep(s_axis_tkeep),
        .in_tvalid(s_axis_tvalid), .in_tready(s_axis_tready),
        .out(pay_if.src), .desc(desc_if.seg)
    );

    header_builder u_header (
        .clk(clk), .rst(rst), .desc(desc_if.hdr),
        .bth_valid(m_roce_bth_valid), .bth_ready(m_roce_bth_ready),
        .bth_op_code(m_roce_bth_op_code), .bth_psn(m_roce_bth_psn),
        .bth_dest_qp(m_roce_bth_dest_qp), .bth_src_qp(m_roce_bth_src_qp),
        .reth_valid(m_roce_reth_valid), .reth_ready(m_roce_reth_ready),
        .reth_v_addr(m_roce_reth_v_addr), .reth_r_key(m_roce_reth_r_key),
        .reth_length(m_roce_reth_length),
        .immdh_valid(m_roce_immdh_valid), .immdh_ready(m_roce_immdh_ready),
        .immdh_data(m_roce_immdh_data), .udp_length(m_udp_length)
    );

    payload_skid_buffer #(.data_width(data_width)) u_skid (
        .clk(clk), .rst(rst), .in(pay_if.snk),
        .m_tdata(m_roce_payload_axis_tdata), .m_tkeep(m_roce_payload_axis_tkeep),
        .m_tvalid(m_roce_payload_axis_tvalid), .m_tready(m_roce_payload_axis_tready),
        .m_tlast(m_roce_payload_axis_tlast)
    );

endmodule

`default_nettype wire

//--- payload_skid_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module payload_skid_buffer #(
    parameter int data_width = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    payload_stream_if.snk           in,
    output logic [data_width-1:0]   m_tdata,
    output logic [data_width/8-1:0] m_tkeep,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    m_tlast
);

    logic [data_width-1:0]   tmp_tdata;
    logic [data_width/8-1:0] tmp_tkeep;
    logic                    tmp_tvalid;
    logic                    tmp_tlast;
    logic                    ready_early;
    logic                    to_out;
    logic                    to_tmp;
    logic                    tmp_to_out;

    // ready for next cycle when the sink drains or nothing is held
    assign ready_early = m_tready || (!tmp_tvalid && !m_tvalid);

    always_comb begin
        to_out     = 1'b0;
        to_tmp     = 1'b0;
        tmp_to_out = 1'b0;
        if (in.tready) begin
            if (m_tready || !m_tvalid) begin
                to_out = 1'b1;
            end else begin
                to_tmp = 1'b1;
            end
        end else if (m_tready) begin
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (to_out) begin
            m_tdata <= in.tdata;
            m_tkeep <= in.tkeep;
            m_tlast <= in.tlast;
        end else if (tmp_to_out) begin
            m_tdata <= tmp_tdata;
            m_tkeep <= tmp_tkeep;
            m_tlast <= tmp_tlast;
        end

        if (to_tmp) begin
            tmp_tdata <= in.tdata;
            tmp_tkeep <= in.tkeep;
            tmp_tlast <= in.tlast;
        end

        if (rst) begin
            in.tready  <= 1'b0;
            m_tvalid   <= 1'b0;
            tmp_tvalid <= 1'b0;
        end else begin
            in.tready <= ready_early;
            if (to_out) begin
                m_tvalid <= in.tvalid;
            end else if (tmp_to_out) begin
                m_tvalid <= tmp_tvalid;
            end
            if (to_tmp) begin
                tmp_tvalid <= in.tvalid;
            end else if (tmp_to_out) begin
                tmp_tvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- header_builder.sv
`timescale 1ns/100ps
`default_nettype none

module header_builder
    import roce_proto_pkg::*, roce_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    packet_desc_if.hdr        desc,
    output logic              bth_valid,
    input  logic              bth_ready,
    output opcode_t           bth_op_code,
    output psn_t              bth_psn,
    output qpn_t              bth_dest_qp,
    output qpn_t              bth_src_qp,
    output logic              reth_valid,
    input  logic              reth_ready,
    output logic [63:0]       reth_v_addr,
    output logic [31:0]       reth_r_key,
    output dma_len_t          reth_length,
    output logic              immdh_valid,
    input  logic              immdh_ready,
    output logic [31:0]       immdh_data,
    output logic [15:0]       udp_length
);

    opcode_t     op_q;
    logic [4:0]  op_sel;
    logic        send_reth;
    logic        send_imm;
    logic [15:0] udp_sum;

    always_comb begin
        send_reth = desc.is_write && desc.first;
        send_imm  = desc.is_imm && desc.last;

        case ({desc.first, desc.last})
            2'b11: begin
                if (desc.is_write) begin
                    op_sel = send_imm ? op_write_only_imd : op_write_only;
                end else begin
                    op_sel = send_imm ? op_send_only_imd : op_send_only;
                end
            end
            2'b10: op_sel = desc.is_write ? op_write_first : op_send_first;
            2'b01: begin
                if (desc.is_write) begin
                    op_sel = send_imm ? op_write_last_imd : op_write_last;
                end else begin
                    op_sel = send_imm ? op_send_last_imd : op_send_last;
                end
            end
            default: op_sel = desc.is_write ? op_write_middle : op_send_middle;
        endcase

        // payload + BTH + optional RETH / IMMDH + UDP header
        udp_sum = 16'(desc.pkt_len) + 16'(bth_bytes + udp_hdr_bytes);
        if (send_reth) begin
            udp_sum = udp_sum + 16'(reth_bytes);
        end
        if (send_imm) begin
            udp_sum = udp_sum + 16'(immdh_bytes);
        end
    end

    always_ff @(posedge clk) begin
        if (desc.start) begin
            op_q.fields.transport <= transport_rc;
            op_q.fields.operation <= op_sel;
            bth_psn               <= desc.psn;
            bth_dest_qp           <= desc.rem_qpn;
            bth_src_qp            <= desc.loc_qpn;
            udp_length            <= udp_sum;
            if (send_reth) begin
                reth_v_addr <= desc.rem_addr;
                reth_r_key  <= desc.r_key;
                reth_length <= desc.dma_len;
            end
            if (send_imm) begin
                immdh_data <= desc.imm_data;
            end
        end

        if (rst) begin
            bth_valid   <= 1'b0;
            reth_valid  <= 1'b0;
            immdh_valid <= 1'b0;
        end else if (desc.start) begin
            bth_valid   <= 1'b1;
            reth_valid  <= send_reth;
            immdh_valid <= send_imm;
        end else begin
            bth_valid   <= bth_valid && !bth_ready;
            reth_valid  <= reth_valid && !reth_ready;
            immdh_valid <= immdh_valid && !immdh_ready;
        end
    end

    assign bth_op_code.raw = op_q.raw;

    // held off the next packet start until all headers are taken
    assign desc.busy = bth_valid || reth_valid || immdh_valid;

endmodule

`default_nettype wire

//--- tx_segmenter.sv
`timescale 1ns/100ps
`default_nettype none

module tx_segmenter
    import roce_cfg_pkg::*;
#(
    parameter int data_width = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  pmtu_code_t              pmtu,
    input  logic                    meta_valid,
    output logic                    meta_ready,
    input  dma_len_t                dma_length,
    input  qpn_t                    rem_qpn,
    input  qpn_t                    loc_qpn,
    input  psn_t                    rem_psn,
    input  logic [31:0]             r_key,
    input  logic [31:0]             imm_data,
    input  logic [63:0]             rem_addr,
    input  logic                    is_imm,
    input  logic                    is_write,
    input  logic [data_width-1:0]   in_tdata,
    input  logic [data_width/8-1:0] in_tkeep,
    input  logic                    in_tvalid,
    output logic                    in_tready,
    payload_stream_if.src           out,
    packet_desc_if.seg              desc
);

    localparam int beat_bytes = data_width / 8;

    localparam logic st_idle = 1'b0;
    localparam logic st_pkt  = 1'b1;

    logic     state;
    logic     meta_en;
    logic     at_start;
    logic     first_pkt;
    pkt_len_t pmtu_bytes;
    dma_len_t rem_bytes;
    pkt_len_t pkt_left;
    pkt_len_t left_now;
    psn_t     psn;
    logic     pass;
    logic     meta_fire;
    logic     beat_fire;
    logic     pkt_end;
    logic     xfer_end;

    assign meta_ready = meta_en && !desc.busy;
    assign meta_fire  = meta_valid && meta_ready;

    // first beat of a packet waits until the previous headers are taken
    assign pass      = (state == st_pkt) && !(at_start && desc.busy);
    assign in_tready = pass && out.tready;
    assign beat_fire = in_tvalid && in_tready;

    assign desc.last    = rem_bytes <= dma_len_t'(pmtu_bytes);
    assign desc.pkt_len = desc.last ? pkt_len_t'(rem_bytes) : pmtu_bytes;
    assign desc.first   = first_pkt;
    assign desc.psn     = psn;
    assign desc.start   = beat_fire && at_start;

    assign left_now = at_start ? desc.pkt_len : pkt_left;
    assign pkt_end  = left_now <= pkt_len_t'(beat_bytes);
    assign xfer_end = rem_bytes <= dma_len_t'(beat_bytes);

    assign out.tdata  = in_tdata;
    assign out.tkeep  = in_tkeep;
    assign out.tvalid = in_tvalid && pass;
    assign out.tlast  = pkt_end;

    always_ff @(posedge clk) begin
        pmtu_bytes <= pkt_len_t'(pmtu_base_bytes) << pmtu;

        if (meta_fire) begin
            desc.is_write <= is_write;
            desc.is_imm   <= is_imm;
            desc.imm_data <= imm_data;
            desc.rem_qpn  <= rem_qpn;
            desc.loc_qpn  <= loc_qpn;
            desc.rem_addr <= rem_addr;
            desc.r_key    <= r_key;
            desc.dma_len  <= dma_length;
        end

        if (rst) begin
            state     <= st_idle;
            meta_en   <= 1'b0;
            at_start  <= 1'b0;
            first_pkt <= 1'b0;
            rem_bytes <= '0;
            pkt_left  <= '0;
            psn       <= '0;
        end else if (state == st_idle) begin
            if (meta_fire) begin
                state     <= st_pkt;
                meta_en   <= 1'b0;
                at_start  <= 1'b1;
                first_pkt <= 1'b1;
                rem_bytes <= dma_length;
                psn       <= rem_psn;
            end else begin
                meta_en <= 1'b1;
            end
        end else if (beat_fire) begin
            rem_bytes <= rem_bytes - dma_len_t'(beat_bytes);
            pkt_left  <= left_now - pkt_len_t'(beat_bytes);
            at_start  <= pkt_end;
            if (at_start) begin
                first_pkt <= 1'b0;
                psn       <= psn + psn_t'(1);
            end
            if (xfer_end) begin
                state   <= st_idle;
                meta_en <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- packet_desc_if.sv
`timescale 1ns/100ps
`default_nettype none

interface packet_desc_if
    import roce_cfg_pkg::*;
();

    // per packet fields valid while start is high
    logic        start;
    logic        first;
    logic        last;
    pkt_len_t    pkt_len;
    psn_t        psn;
    // per transfer
    logic        is_write;
    logic        is_imm;
    logic [31:0] imm_data;
    qpn_t        rem_qpn;
    qpn_t        loc_qpn;
    logic [63:0] rem_addr;
    logic [31:0] r_key;
    dma_len_t    dma_len;
    // headers still waiting
    logic        busy;

    modport seg (
        output start, first, last, pkt_len, psn,
        output is_write, is_imm, imm_data, rem_qpn, loc_qpn, rem_addr, r_key, dma_len,
        input  busy
    );

    modport hdr (
        input  start, first, last, pkt_len, psn,
        input  is_write, is_imm, imm_data, rem_qpn, loc_qpn, rem_addr, r_key, dma_len,
        output busy
    );

endinterface

`default_nettype wire

//--- payload_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

interface payload_stream_if #(
    parameter int data_width = 64
) ();

    logic [data_width-1:0]   tdata;
    logic [data_width/8-1:0] tkeep;
    logic                    tvalid;
    logic                    tready;
    logic                    tlast;

    modport src (output tdata, tkeep, tvalid, tlast, input tready);
    modport snk (input tdata, tkeep, tvalid, tlast, output tready);

endinterface

`default_nettype wire

//--- roce_cfg_pkg.sv
`default_nettype none

package roce_cfg_pkg;

    typedef logic [31:0] dma_len_t;
    typedef logic [13:0] pkt_len_t;
    typedef logic [23:0] psn_t;
    typedef logic [23:0] qpn_t;
    typedef logic [2:0]  pmtu_code_t;

    // pmtu code 0 is 256 bytes, each step doubles
    localparam int pmtu_base_bytes = 256;

endpackage

`default_nettype wire

//--- roce_proto_pkg.sv
`default_nettype none

package roce_proto_pkg;

    // opcode byte read raw or as transport and operation
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] transport;
            logic [4:0] operation;
        } fields;
    } opcode_t;

    localparam logic [2:0] transport_rc = 3'd0;

    // RC operation codes
    localparam logic [4:0] op_send_first     = 5'h00;
    localparam logic [4:0] op_send_middle    = 5'h01;
    localparam logic [4:0] op_send_last      = 5'h02;
    localparam logic [4:0] op_send_last_imd  = 5'h03;
    localparam logic [4:0] op_send_only      = 5'h04;
    localparam logic [4:0] op_send_only_imd  = 5'h05;
    localparam logic [4:0] op_write_first    = 5'h06;
    localparam logic [4:0] op_write_middle   = 5'h07;
    localparam logic [4:0] op_write_last     = 5'h08;
    localparam logic [4:0] op_write_last_imd = 5'h09;
    localparam logic [4:0] op_write_only     = 5'h0a;
    localparam logic [4:0] op_write_only_imd = 5'h0b;

    // header sizes in bytes
    localparam int bth_bytes     = 12;
    localparam int reth_bytes    = 16;
    localparam int immdh_bytes   = 4;
    localparam int udp_hdr_bytes = 8;

endpackage

`default_nettype wire
